/* src/snd_defines.svh */
// sound board constants: ram size, pitch width and pcm register offsets
`ifndef SND_DEFINES_SVH
`define SND_DEFINES_SVH

`define SND_RAM_AW  11   // 2 KB work ram
`define SND_PITCH_W 12   // pitch counter width

// pcm register offsets, relative to the channel base
`define SND_REG_PITCH_LO  4'd0
`define SND_REG_PITCH_HI  4'd1   // low nibble only
`define SND_REG_START_LO  4'd2
`define SND_REG_START_MID 4'd3
`define SND_REG_START_HI  4'd4   // bit 16 in data bit 0
`define SND_REG_TRIG      4'd5
`define SND_REG_CH_B      4'd6   // channel b bank base
`define SND_REG_VOL       4'd12  // a low nibble, b high nibble

`endif

/* src/snd_pkg.sv */
// sound board types shared by the bus decoder and the pcm engine
package snd_pkg;

`include "snd_defines.svh"

    typedef logic [15:0]             cpu_addr_t;
    typedef logic [7:0]              cpu_data_t;
    typedef logic [`SND_PITCH_W-1:0] pitch_t;
    typedef logic [3:0]              vol_t;
    typedef logic [18:0]             smp_addr_t;  // bank msbs + channel address
    typedef logic [19:0]             rom_addr_t;  // top bit picks the channel
    typedef logic signed [11:0]      pcm_t;

    typedef enum logic {board_a, board_b} board_e;
    typedef enum logic [1:0] {idle, fetch_a, fetch_b} fetch_state_e;

    // wishbone classic, cpu side
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        cpu_addr_t adr;
        cpu_data_t dat;
    } wb_req_t;

    typedef struct packed {
        cpu_data_t dat;
        logic      ack;
    } wb_rsp_t;

    // sample rom, cs/ok handshake
    typedef struct packed {
        logic      cs;
        rom_addr_t addr;
    } rom_req_t;

    typedef struct packed {
        logic       ok;
        logic [7:0] data;
    } rom_rsp_t;

    typedef struct packed {
        logic       we;
        logic [3:0] off;
        cpu_data_t  dat;
    } pcm_wr_t;

endpackage

/* src/snd_map.sv */
// sound cpu address decoder, bank register and wishbone slave port
`timescale 1ns/10ps
`include "snd_defines.svh"

module snd_map (
    input  logic                   clk,
    input  logic                   rst,
    input  snd_pkg::board_e        board,
    input  snd_pkg::wb_req_t       wb_req,
    output snd_pkg::wb_rsp_t       wb_rsp,
    input  snd_pkg::cpu_data_t     snd_latch,
    input  snd_pkg::cpu_data_t     ram_rdata,
    output logic                   ram_we,
    output logic [`SND_RAM_AW-1:0] ram_addr,
    output snd_pkg::cpu_data_t     ram_wdata,
    input  logic [1:0]             pcm_status,
    output snd_pkg::pcm_wr_t       pcm_wr,
    output logic [1:0]             msb_a,
    output logic [1:0]             msb_b
);
    import snd_pkg::*;

    logic       ack;
    logic       acc_go;    // request seen, ack rises on this edge
    logic       wr_go;
    logic       upper;     // adr >= 0x8000
    logic       sel_ram, sel_latch, sel_pcm, sel_bank;
    logic [3:0] bank;      // {b msbs, a msbs}
    cpu_data_t  rd_mux;

    assign acc_go = wb_req.cyc & wb_req.stb & ~ack;
    assign wr_go  = acc_go & wb_req.we;
    assign upper  = wb_req.adr[15];

    // one-hot region decode, fm falls through to the 0xff default
    always_comb begin
        sel_ram   = 1'b0;
        sel_latch = 1'b0;
        sel_pcm   = 1'b0;
        sel_bank  = 1'b0;
        if (board == board_a) begin
            sel_ram   = upper && wb_req.adr[14:13] == 2'd0;  // 8000
            sel_latch = upper && wb_req.adr[14:13] == 2'd2;  // c000
            sel_pcm   = upper && wb_req.adr[14:13] == 2'd3;  // e000
        end else begin
            sel_ram   = upper && wb_req.adr[14:12] == 3'd0;  // 8000
            sel_latch = upper && wb_req.adr[14:12] == 3'd2;  // a000
            sel_pcm   = upper && wb_req.adr[14:12] == 3'd3;  // b000
            sel_bank  = upper && wb_req.adr[14:12] == 3'd7;  // f000, write only
        end
    end

    always_comb begin
        case (1'b1)
            sel_ram:   rd_mux = ram_rdata;
            sel_latch: rd_mux = snd_latch;
            sel_pcm:   rd_mux = {6'd0, pcm_status};  // busy flags
            default:   rd_mux = 8'hff;               // fm, bank, unmapped
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack  <= 1'b0;
            bank <= 4'd0;
        end else begin
            ack <= acc_go;  // single cycle, drops once seen high
            if (wr_go && sel_bank) bank <= wb_req.dat[3:0];
        end
    end

    assign wb_rsp.ack = ack;
    assign wb_rsp.dat = rd_mux;

    // ram mirrors across its region
    assign ram_we    = wr_go & sel_ram;
    assign ram_addr  = wb_req.adr[`SND_RAM_AW-1:0];
    assign ram_wdata = wb_req.dat;

    assign pcm_wr.we  = wr_go & sel_pcm;
    assign pcm_wr.off = wb_req.adr[3:0];
    assign pcm_wr.dat = wb_req.dat;

    // map a has no bank latch, msbs stay low
    assign msb_a = (board == board_b) ? bank[1:0] : 2'd0;
    assign msb_b = (board == board_b) ? bank[3:2] : 2'd0;

endmodule

/* src/snd_ram.sv */
// sound cpu work ram, synchronous write and asynchronous read
`timescale 1ns/10ps
`include "snd_defines.svh"

module snd_ram #(
    parameter int AW = `SND_RAM_AW
) (
    input  logic               clk,
    input  logic               we,
    input  logic [AW-1:0]      addr,
    input  snd_pkg::cpu_data_t wdata,
    output snd_pkg::cpu_data_t rdata
);
    import snd_pkg::*;

    cpu_data_t mem [2**AW];  // contents undefined at power up

    always_ff @(posedge clk) begin
        if (we) mem[addr] <= wdata;
    end

    assign rdata = mem[addr];

endmodule

/* src/pcm_rate.sv */
// per channel pitch counters, one step pulse on each overflow
`timescale 1ns/10ps

module pcm_rate (
    input  logic             clk,
    input  logic             rst,
    input  logic             cen,
    input  logic [1:0]       busy,
    input  logic [1:0]       load,
    input  snd_pkg::pitch_t  pitch_a,
    input  snd_pkg::pitch_t  pitch_b,
    output logic [1:0]       step
);
    import snd_pkg::*;

    pitch_t cnt   [2];
    pitch_t pitch [2];

    assign pitch[0] = pitch_a;
    assign pitch[1] = pitch_b;

    // period is 4096 - pitch cen ticks
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt[0] <= '0;
            cnt[1] <= '0;
            step   <= 2'b00;
        end else begin
            for (int i = 0; i < 2; i++) begin
                step[i] <= 1'b0;
                if (load[i]) begin
                    cnt[i] <= pitch[i];  // restart on trigger
                end else if (busy[i] && cen) begin
                    if (&cnt[i]) begin
                        cnt[i]  <= pitch[i];
                        step[i] <= 1'b1;
                    end else begin
                        cnt[i] <= cnt[i] + 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* src/pcm_fetch.sv */
// pcm channel registers and sample rom fetch sequencer
`timescale 1ns/10ps
`include "snd_defines.svh"

module pcm_fetch (
    input  logic              clk,
    input  logic              rst,
    input  snd_pkg::pcm_wr_t  pcm_wr,
    input  logic [1:0]        msb_a,
    input  logic [1:0]        msb_b,
    input  logic [1:0]        step,
    output logic [1:0]        load,
    output snd_pkg::pitch_t   pitch_a,
    output snd_pkg::pitch_t   pitch_b,
    output snd_pkg::vol_t     vol_a,
    output snd_pkg::vol_t     vol_b,
    output logic [1:0]        busy,
    output snd_pkg::rom_req_t rom_req,
    input  snd_pkg::rom_rsp_t rom_rsp,
    output logic [1:0]        smp_we,
    output logic [6:0]        smp
);
    import snd_pkg::*;

    fetch_state_e state;
    pitch_t       pitch_r [2];
    logic [16:0]  start_r [2];
    logic [16:0]  play    [2];    // running sample address
    smp_addr_t    ch_addr [2];
    logic [1:0]   pend;           // step waiting for a fetch
    logic         wr_ch;          // 1 = channel b register
    logic [3:0]   wr_reg;
    logic [1:0]   trig;
    logic         cur;            // channel being fetched
    logic [1:0]   fin;            // fetch done, per channel
    logic         end_mark;

    always_comb begin
        wr_ch  = pcm_wr.off >= `SND_REG_CH_B;
        wr_reg = wr_ch ? pcm_wr.off - `SND_REG_CH_B : pcm_wr.off;
        trig   = 2'b00;
        if (pcm_wr.we && pcm_wr.off < `SND_REG_VOL && wr_reg == `SND_REG_TRIG)
            trig[wr_ch] = 1'b1;
    end

    assign load       = trig;        // counter restarts with busy
    assign ch_addr[0] = {msb_a, play[0]};
    assign ch_addr[1] = {msb_b, play[1]};
    assign cur        = state == fetch_b;
    assign fin        = (state != idle && rom_rsp.ok) ? (2'b01 << cur) : 2'b00;
    assign end_mark   = rom_rsp.data[7];
    assign smp_we     = fin;
    assign smp        = end_mark ? 7'd0 : rom_rsp.data[6:0];  // marker plays zero
    assign pitch_a    = pitch_r[0];
    assign pitch_b    = pitch_r[1];

    // cpu side registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pitch_r[0] <= '0;
            pitch_r[1] <= '0;
            start_r[0] <= '0;
            start_r[1] <= '0;
            vol_a      <= '0;
            vol_b      <= '0;
        end else if (pcm_wr.we) begin
            if (pcm_wr.off == `SND_REG_VOL) begin
                vol_a <= pcm_wr.dat[3:0];
                vol_b <= pcm_wr.dat[7:4];
            end else if (pcm_wr.off < `SND_REG_VOL) begin
                case (wr_reg)
                    `SND_REG_PITCH_LO:  pitch_r[wr_ch][7:0]  <= pcm_wr.dat;
                    `SND_REG_PITCH_HI:  pitch_r[wr_ch][11:8] <= pcm_wr.dat[3:0];
                    `SND_REG_START_LO:  start_r[wr_ch][7:0]  <= pcm_wr.dat;
                    `SND_REG_START_MID: start_r[wr_ch][15:8] <= pcm_wr.dat;
                    `SND_REG_START_HI:  start_r[wr_ch][16]   <= pcm_wr.dat[0];
                    default: ;  // trigger decoded above
                endcase
            end
        end
    end

    // channel state and rom sequencer, a has priority
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= idle;
            rom_req.cs   <= 1'b0;
            rom_req.addr <= '0;
            busy         <= 2'b00;
            pend         <= 2'b00;
            play[0]      <= '0;
            play[1]      <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (trig[i]) begin
                    play[i] <= start_r[i];
                    busy[i] <= 1'b1;
                    pend[i] <= 1'b0;
                end else if (fin[i]) begin
                    play[i] <= play[i] + 1'b1;
                    pend[i] <= step[i] & ~end_mark;  // fresh step queues next byte
                    if (end_mark) busy[i] <= 1'b0;
                end else if (step[i] && busy[i]) begin
                    pend[i] <= 1'b1;                 // merges with an open request
                end
            end
            case (state)
                idle: begin
                    if (pend[0] && !trig[0]) begin
                        state        <= fetch_a;
                        rom_req.cs   <= 1'b1;
                        rom_req.addr <= {1'b0, ch_addr[0]};
                    end else if (pend[1] && !trig[1]) begin
                        state        <= fetch_b;
                        rom_req.cs   <= 1'b1;
                        rom_req.addr <= {1'b1, ch_addr[1]};
                    end
                end
                default: begin
                    if (rom_rsp.ok) begin  // cs and addr held until here
                        state      <= idle;
                        rom_req.cs <= 1'b0;
                    end
                end
            endcase
        end
    end

endmodule

/* src/pcm_mix.sv */
// pcm mixer, volume scaling and registered sum of both channels
`timescale 1ns/10ps

module pcm_mix (
    input  logic          clk,
    input  logic          rst,
    input  logic [1:0]    smp_we,
    input  logic [6:0]    smp,
    input  snd_pkg::vol_t vol_a,
    input  snd_pkg::vol_t vol_b,
    output snd_pkg::pcm_t pcm
);
    import snd_pkg::*;

    logic [6:0]        last_a, last_b;  // held sample per channel
    logic [6:0]        cur_a, cur_b;
    logic signed [7:0] off_a, off_b;    // -64..63
    pcm_t              prod_a, prod_b;

    // new sample bypasses the store so pcm lands one cycle after ok
    assign cur_a  = smp_we[0] ? smp : last_a;
    assign cur_b  = smp_we[1] ? smp : last_b;
    assign off_a  = $signed({1'b0, cur_a}) - 8'sd64;
    assign off_b  = $signed({1'b0, cur_b}) - 8'sd64;
    assign prod_a = off_a * $signed({1'b0, vol_a});  // at most +-960
    assign prod_b = off_b * $signed({1'b0, vol_b});

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_a <= 7'd0;
            last_b <= 7'd0;
            pcm    <= '0;
        end else if (|smp_we) begin
            last_a <= cur_a;
            last_b <= cur_b;
            pcm    <= prod_a + prod_b;  // fits 12 bits signed
        end
    end

endmodule

/* src/snd_top.sv */
// sound board top, cpu bus decode, work ram and two channel pcm engine
`timescale 1ns/10ps
`include "snd_defines.svh"

module snd_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  snd_pkg::board_e    board,
    input  snd_pkg::cpu_data_t snd_latch,
    input  snd_pkg::wb_req_t   wb_req,
    output snd_pkg::wb_rsp_t   wb_rsp,
    output snd_pkg::rom_req_t  rom_req,
    input  snd_pkg::rom_rsp_t  rom_rsp,
    output snd_pkg::pcm_t      pcm
);
    import snd_pkg::*;

    logic                   ram_we;
    logic [`SND_RAM_AW-1:0] ram_addr;
    cpu_data_t              ram_wdata, ram_rdata;
    pcm_wr_t                pcm_wr;
    logic [1:0]             msb_a, msb_b;
    logic [1:0]             busy, load, step, smp_we;
    pitch_t                 pitch_a, pitch_b;
    vol_t                   vol_a, vol_b;
    logic [6:0]             smp;

    snd_map u_map (
        .clk        (clk),
        .rst        (rst),
        .board      (board),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .snd_latch  (snd_latch),
        .ram_rdata  (ram_rdata),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata),
        .pcm_status (busy),        // status byte bits 1:0
        .pcm_wr     (pcm_wr),
        .msb_a      (msb_a),
        .msb_b      (msb_b)
    );

    snd_ram #(.AW(`SND_RAM_AW)) u_ram (
        .clk   (clk),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    pcm_rate u_rate (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .busy    (busy),
        .load    (load),
        .pitch_a (pitch_a),
        .pitch_b (pitch_b),
        .step    (step)
    );

    pcm_fetch u_fetch (
        .clk     (clk),
        .rst     (rst),
        .pcm_wr  (pcm_wr),
        .msb_a   (msb_a),
        .msb_b   (msb_b),
        .step    (step),
        .load    (load),
        .pitch_a (pitch_a),
        .pitch_b (pitch_b),
        .vol_a   (vol_a),
        .vol_b   (vol_b),
        .busy    (busy),
        .rom_req (rom_req),
        .rom_rsp (rom_rsp),
        .smp_we  (smp_we),
        .smp     (smp)
    );

    pcm_mix u_mix (
        .clk    (clk),
        .rst    (rst),
        .smp_we (smp_we),
        .smp    (smp),
        .vol_a  (vol_a),
        .vol_b  (vol_b),
        .pcm    (pcm)
    );

endmodule

/* dv/snd_tb.sv */
// sound board testbench with cpu bus master, sample rom responder and pcm mix model
`timescale 1ns/10ps
`include "snd_defines.svh"

module snd_tb;
    import snd_pkg::*;

    localparam int     N_ACC    = 300;   // random bus accesses per board
    localparam int     N_ROUNDS = 12;    // trigger rounds per board
    localparam int     MAX_RUN  = 40;    // bytes per channel run with margin
    localparam int     CYC_OP   = 200;   // worst case cycles per access or sample
    localparam int     MAX_POLL = 4000;  // status reads before giving up
    localparam int     N_OPS    = 2 * (N_ACC + N_ROUNDS * (12 + 2 * MAX_RUN));
    localparam longint WD_NS    = 64'd2 * N_OPS * CYC_OP * 100;  // 2x margin

    typedef enum logic [2:0] {r_ff, r_ram, r_latch, r_pcm, r_bank} region_e;

    logic      clk;
    logic      rst;
    logic      cen;
    board_e    board;
    cpu_data_t snd_latch;
    wb_req_t   wb_req;
    wb_rsp_t   wb_rsp;
    rom_req_t  rom_req;
    rom_rsp_t  rom_rsp;
    pcm_t      pcm;

    logic [7:0]  rom_mem  [2**20];            // sample rom image
    logic [2:0]  dly_tab  [256];              // rom wait states 0..5
    logic        cen_tab  [256];
    cpu_data_t   ram_mdl  [2**`SND_RAM_AW];
    logic        ram_ok   [2**`SND_RAM_AW];   // written at least once
    logic [3:0]  bank_mdl;
    vol_t        vol_mdl  [2];
    logic [16:0] play_mdl [2];
    logic [16:0] start_mdl [2];
    logic [6:0]  last_mdl [2];
    logic [1:0]  busy_mdl;

    snd_top DUT (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .board     (board),
        .snd_latch (snd_latch),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .rom_req   (rom_req),
        .rom_rsp   (rom_rsp),
        .pcm       (pcm)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_data(input string name, input cpu_data_t got, input cpu_data_t exp);
        if (got !== exp)
            abort_run($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_ack(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_rom_addr(input string name, input rom_addr_t got, input rom_addr_t exp);
        if (got !== exp)
            abort_run($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_pcm(input string name, input pcm_t got, input pcm_t exp);
        if (got !== exp)
            abort_run($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    // region per board memory map with fm in r_ff
    function automatic region_e region_of(input board_e b, input cpu_addr_t a);
        region_e r;
        r = r_ff;
        if (a[15] && b == board_a) begin
            case (a[14:13])
                2'd0:    r = r_ram;
                2'd2:    r = r_latch;
                2'd3:    r = r_pcm;
                default: r = r_ff;
            endcase
        end else if (a[15]) begin
            case (a[14:12])
                3'd0:    r = r_ram;
                3'd2:    r = r_latch;
                3'd3:    r = r_pcm;
                3'd7:    r = r_bank;
                default: r = r_ff;
            endcase
        end
        return r;
    endfunction

    function automatic logic [1:0] msb_model(input logic ch);
        if (board == board_a)
            return 2'd0;  // no bank latch on map a
        return ch ? bank_mdl[3:2] : bank_mdl[1:0];
    endfunction

    // channel whose model address matches the fetch
    function automatic logic expected_channel(input rom_addr_t a);
        logic hit_a;
        logic hit_b;
        hit_a = busy_mdl[0] && a[18:0] == {msb_model(1'b0), play_mdl[0]};
        hit_b = busy_mdl[1] && a[18:0] == {msb_model(1'b1), play_mdl[1]};
        if (hit_a && hit_b)
            return a[19];        // both channels at the same sample address
        if (hit_a || hit_b)
            return hit_b;
        return !busy_mdl[0];     // mismatch reported against a playing channel
    endfunction

    // signed sample times volume summed over both channels
    function automatic pcm_t mix_model();
        int acc;
        acc = (int'(last_mdl[0]) - 64) * int'(vol_mdl[0])
            + (int'(last_mdl[1]) - 64) * int'(vol_mdl[1]);
        return pcm_t'(acc);
    endfunction

    // one classic cycle with ack expected one clock after stb
    task automatic bus_access(input logic we, input cpu_addr_t adr, input cpu_data_t wdat,
                              output cpu_data_t rdat, output cpu_data_t latch_val);
        wb_req_t req;
        req.cyc   = 1'b1;
        req.stb   = 1'b1;
        req.we    = we;
        req.adr   = adr;
        req.dat   = wdat;
        latch_val = cpu_data_t'($urandom);  // fresh latch value per access
        @(posedge clk);
        wb_req    <= req;
        snd_latch <= latch_val;
        @(negedge clk);
        check_ack("wb_rsp.ack", wb_rsp.ack, 1'b0);
        @(negedge clk);
        check_ack("wb_rsp.ack", wb_rsp.ack, 1'b1);
        rdat = wb_rsp.dat;               // valid while ack high
        @(posedge clk);
        wb_req <= '0;
        @(negedge clk);
        check_ack("wb_rsp.ack", wb_rsp.ack, 1'b0);  // single cycle ack
    endtask

    task automatic bus_write(input cpu_addr_t adr, input cpu_data_t dat);
        cpu_data_t rd;
        cpu_data_t lat;
        bus_access(1'b1, adr, dat, rd, lat);
    endtask

    task automatic random_access();
        cpu_addr_t adr;
        cpu_data_t wd;
        cpu_data_t rd;
        cpu_data_t lat;
        region_e   r;
        logic      we;
        adr = cpu_addr_t'($urandom);
        if ($urandom % 2 == 0)  // bias toward ram including mirrors
            adr = 16'h8000 | (adr & ((board == board_a) ? 16'h1fff : 16'h0fff));
        r  = region_of(board, adr);
        we = 1'($urandom);
        wd = cpu_data_t'($urandom);
        if (r == r_pcm)
            we = 1'b0;          // pcm registers only in the trigger rounds
        if (r == r_ram && !ram_ok[adr[`SND_RAM_AW-1:0]])
            we = 1'b1;
        bus_access(we, adr, wd, rd, lat);
        if (we && r == r_ram) begin
            ram_mdl[adr[`SND_RAM_AW-1:0]] = wd;
            ram_ok[adr[`SND_RAM_AW-1:0]]  = 1'b1;
        end else if (we && r == r_bank) begin
            bank_mdl = wd[3:0];
        end else if (!we) begin
            case (r)
                r_ram:   check_data("wb_rsp.dat", rd, ram_mdl[adr[`SND_RAM_AW-1:0]]);
                r_latch: check_data("wb_rsp.dat", rd, lat);
                r_pcm:   check_data("wb_rsp.dat", rd, {6'd0, busy_mdl});
                default: check_data("wb_rsp.dat", rd, 8'hff);  // fm, bank and open bus
            endcase
        end
    endtask

    task automatic pcm_round();
        cpu_addr_t  base;
        cpu_addr_t  cb;
        cpu_data_t  rd;
        cpu_data_t  lat;
        cpu_data_t  v;
        pitch_t     pitch;
        logic [1:0] mask;
        int         polls;
        base = (board == board_a) ? 16'he000 : 16'hb000;
        // on map a this address is channel a pitch low, written again below
        bank_mdl = 4'($urandom);
        bus_write(16'hf000, {4'h0, bank_mdl});
        v = cpu_data_t'($urandom);
        vol_mdl[0] = v[3:0];
        vol_mdl[1] = v[7:4];
        bus_write(base + `SND_REG_VOL, v);
        for (int ch = 0; ch < 2; ch++) begin
            cb    = base + ((ch == 1) ? `SND_REG_CH_B : 4'd0);
            pitch = pitch_t'(4096 - (2 + $urandom % 23));  // 2..24 ticks per step
            start_mdl[ch] = 17'($urandom);
            bus_write(cb + `SND_REG_PITCH_LO, pitch[7:0]);
            bus_write(cb + `SND_REG_PITCH_HI, {4'h0, pitch[11:8]});
            bus_write(cb + `SND_REG_START_LO, start_mdl[ch][7:0]);
            bus_write(cb + `SND_REG_START_MID, start_mdl[ch][15:8]);
            bus_write(cb + `SND_REG_START_HI, {7'd0, start_mdl[ch][16]});
        end
        mask = 2'(1 + $urandom % 3);  // a, b or both
        for (int ch = 0; ch < 2; ch++) begin
            if (mask[ch]) begin
                cb           = base + ((ch == 1) ? `SND_REG_CH_B : 4'd0);
                play_mdl[ch] = start_mdl[ch];
                busy_mdl[ch] = 1'b1;   // first fetch waits for a step
                bus_write(cb + `SND_REG_TRIG, 8'h00);
            end
        end
        polls = 0;
        do begin
            bus_access(1'b0, base, 8'h00, rd, lat);
            check_data("wb_rsp.dat", rd & 8'hfc, 8'h00);  // upper status bits zero
            for (int ch = 0; ch < 2; ch++) begin
                if (busy_mdl[ch] && !rd[ch])
                    abort_run($sformatf("channel %0d idle before its end marker", ch));
            end
            polls++;
            if (polls > MAX_POLL)
                abort_run("channels still busy after the status polling limit");
        end while (rd[1:0] != 2'b00);
        repeat (20) @(posedge clk);  // stray fetch shows up in the responder
    endtask

    task automatic apply_reset(input board_e b);
        @(posedge clk);
        rst    <= 1'b1;
        board  <= b;
        wb_req <= '0;
        busy_mdl = 2'b00;
        bank_mdl = 4'd0;
        for (int ch = 0; ch < 2; ch++) begin
            last_mdl[ch] = 7'd0;   // reads as -64 in the mix
            play_mdl[ch] = '0;
            vol_mdl[ch]  = '0;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_ack("wb_rsp.ack", wb_rsp.ack, 1'b0);
        check_pcm("pcm", pcm, 12'sd0);
        if (rom_req.cs !== 1'b0)
            abort_run("sample rom chip select not low after reset");
    endtask

    task automatic run_board(input board_e b);
        cpu_data_t rd;
        cpu_data_t lat;
        apply_reset(b);
        bus_access(1'b0, (b == board_a) ? 16'he000 : 16'hb000, 8'h00, rd, lat);
        check_data("wb_rsp.dat", rd, 8'h00);  // both channels idle
        repeat (N_ACC) random_access();
        repeat (N_ROUNDS) pcm_round();
    endtask

    // cen pattern with about three ticks in four
    initial begin : cen_drive
        int idx;
        idx = 0;
        cen = 1'b0;
        forever begin
            @(posedge clk);
            cen <= cen_tab[idx];
            idx = (idx + 1) % 256;
        end
    end

    // answers each chip select after a table driven delay
    initial begin : rom_responder
        rom_addr_t  a;
        logic       ch;
        logic [7:0] b;
        int         idx;
        idx     = 0;
        rom_rsp = '0;
        forever begin
            @(posedge clk);
            if (rom_req.cs) begin
                a = rom_req.addr;
                if (busy_mdl == 2'b00)
                    abort_run("sample fetch while both channels are stopped");
                ch = expected_channel(a);
                check_rom_addr("rom_req.addr", a, {ch, msb_model(ch), play_mdl[ch]});
                repeat (dly_tab[idx]) @(posedge clk);
                idx = (idx + 1) % 256;
                b   = rom_mem[a];
                rom_rsp <= {1'b1, b};
                play_mdl[ch] = play_mdl[ch] + 17'd1;
                if (b[7]) begin
                    last_mdl[ch] = 7'd0;   // end marker plays zero
                    busy_mdl[ch] = 1'b0;
                end else begin
                    last_mdl[ch] = b[6:0];
                end
                @(posedge clk);
                rom_rsp <= '0;
                @(negedge clk);
                check_pcm("pcm", pcm, mix_model());  // one cycle after ok
            end
        end
    end

    initial begin : watchdog
        #(WD_NS);
        abort_run($sformatf("watchdog expired at %0t, the DUT stopped making progress", $time));
    end

    initial begin : main
        int seed_ret;
        int next_mark;
        seed_ret  = $urandom(32'hfe43);
        rst       = 1'b1;
        board     = board_a;
        snd_latch = 8'h00;
        wb_req    = '0;
        for (int i = 0; i < 256; i++) begin
            dly_tab[i] = 3'($urandom % 6);
            cen_tab[i] = ($urandom % 4) != 0;
        end
        for (int i = 0; i < 2**`SND_RAM_AW; i++)
            ram_ok[i] = 1'b0;
        next_mark = 4 + $urandom % 17;
        for (int i = 0; i < 2**20; i++) begin
            if (i == next_mark) begin
                rom_mem[i] = 8'($urandom) | 8'h80;  // end marker
                next_mark  = next_mark + 4 + $urandom % 17;
            end else begin
                rom_mem[i] = 8'($urandom) & 8'h7f;
            end
        end
        run_board(board_a);
        run_board(board_b);  // fresh reset with ram contents kept
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* sources.f */
+incdir+src
src/snd_pkg.sv
src/snd_map.sv
src/snd_ram.sv
src/pcm_rate.sv
src/pcm_fetch.sv
src/pcm_mix.sv
src/snd_top.sv
dv/snd_tb.sv

/* Makefile */
# Verilator build and run of the sound board testbench

VERILATOR ?= verilator
TOP       ?= snd_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
